// File: alut_addr_checker.sv
// pkt_valid must only come while busy is low; fixed 2 cycle latency to fwd_valid, no back-pressure
`timescale 1ns/1ps
`default_nettype none

module alut_addr_checker
   import alut_entry_pkg::*;
   import alut_ctrl_pkg::*;
(
   input  wire logic                pclk4,
   input  wire logic                rst_n,
   // frame in
   input  wire logic                pkt_valid,
   input  wire logic [mac_w-1:0]    src_mac,
   input  wire logic [mac_w-1:0]    dst_mac,
   input  wire logic [port_w-1:0]   src_port,
   input  wire logic [stamp_w-1:0]  now,
   // forwarding result
   output logic                     busy,
   output logic                     fwd_valid,
   output logic                     fwd_hit,
   output logic      [port_w-1:0]   fwd_port,
   // memory port
   output logic      [alut_aw-1:0]  mem_addr,
   output logic                     mem_write,
   output logic      [entry_w-1:0]  mem_wdata,
   input  wire logic [entry_w-1:0]  mem_rdata
);

   addr_state_e       state;
   logic [mac_w-1:0]  src_mac_q;     // frame fields held for the lookup
   logic [mac_w-1:0]  dst_mac_q;
   logic [port_w-1:0] src_port_q;
   logic              dst_hit;       // compare on returned entry

   // --------------------------------------------------
   // frame capture
   // --------------------------------------------------
   always_ff @(posedge pclk4)
   begin
      if (pkt_valid && state == addr_idle)
      begin
         src_mac_q  <= src_mac;
         dst_mac_q  <= dst_mac;
         src_port_q <= src_port;
      end
   end

   // --------------------------------------------------
   // fsm, idle -> lookup -> resolve -> idle
   // --------------------------------------------------
   always_ff @(posedge pclk4 or negedge rst_n)
   begin
      if (!rst_n)
         state <= addr_idle;
      else
      begin
         case (state)
            addr_idle:    if (pkt_valid) state <= addr_lookup;
            addr_lookup:  state <= addr_resolve;   // dst read on this edge
            addr_resolve: state <= addr_idle;      // learn write on this edge
            default:      state <= addr_idle;
         endcase
      end
   end

   assign busy = (state != addr_idle);   // covers lookup and resolve

   // entry must be valid and hold the same mac, a collision is a miss
   assign dst_hit = mem_rdata[ent_valid_b] &&
                    (mem_rdata[ent_mac_lo +: mac_w] == dst_mac_q);

   // --------------------------------------------------
   // memory port drive
   // --------------------------------------------------
   always_comb
   begin
      mem_write = (state == addr_resolve);
      if (state == addr_resolve)
         mem_addr = alut_hash(src_mac_q);   // learn the source
      else
         mem_addr = alut_hash(dst_mac_q);   // lookup the destination
      // learn entry, layout valid/port/mac/stamp
      mem_wdata = {1'b1, src_port_q, src_mac_q, now};
   end

   // --------------------------------------------------
   // registered forwarding result, one cycle pulse
   // --------------------------------------------------
   always_ff @(posedge pclk4 or negedge rst_n)
   begin
      if (!rst_n)
      begin
         fwd_valid <= 1'b0;
         fwd_hit   <= 1'b0;
         fwd_port  <= '0;
      end
      else
      begin
         fwd_valid <= (state == addr_resolve);
         if (state == addr_resolve)
         begin
            fwd_hit  <= dst_hit;
            fwd_port <= dst_hit ? mem_rdata[ent_port_lo +: port_w] : '0;  // miss floods
         end
      end
   end

endmodule

`default_nettype wire

// File: alut_age_checker.sv
// age_start is ignored while age_busy is high; visits stall and repeat whenever the learn side is busy
`timescale 1ns/1ps
`default_nettype none

module alut_age_checker
   import alut_entry_pkg::*;
   import alut_ctrl_pkg::*;
(
   input  wire logic                pclk4,
   input  wire logic                rst_n,
   input  wire logic                busy,          // learn side in flight
   input  wire logic                age_start,
   input  wire logic [stamp_w-1:0]  age_limit,
   input  wire logic [stamp_w-1:0]  now,
   output logic                     init_done,
   output logic                     age_busy,
   output logic                     age_done,
   output logic      [alut_aw:0]    age_purged,    // 0..256
   // memory port
   output logic      [alut_aw-1:0]  mem_addr,
   output logic                     mem_write,
   output logic      [entry_w-1:0]  mem_wdata,
   input  wire logic [entry_w-1:0]  mem_rdata
);

   age_state_e         state;
   logic [alut_aw-1:0] idx;          // shared by init clear and sweep
   logic [stamp_w-1:0] age_diff;     // modulo 2^32 age
   logic               stale;

   assign age_diff = now - mem_rdata[ent_stamp_lo +: stamp_w];
   assign stale    = mem_rdata[ent_valid_b] && (age_diff > age_limit);

   // --------------------------------------------------
   // fsm and index counter
   // --------------------------------------------------
   always_ff @(posedge pclk4 or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state      <= age_init;
         idx        <= '0;
         age_purged <= '0;
      end
      else
      begin
         case (state)
            age_init:
            begin
               idx <= idx + 1'b1;                 // one zero write per cycle
               if (idx == alut_aw'(alut_depth - 1))
                  state <= age_idle;
            end
            age_idle:
            begin
               if (age_start)
               begin
                  idx        <= '0;
                  age_purged <= '0;
                  state      <= age_read;
               end
            end
            age_read:
               if (!busy) state <= age_check;     // read issued this edge
            age_check:
            begin
               if (busy)
                  state <= age_read;              // frame started, redo this index
               else
               begin
                  if (stale)
                     age_purged <= age_purged + 1'b1;
                  idx <= idx + 1'b1;
                  if (idx == alut_aw'(alut_depth - 1))
                     state <= alut_ctrl_pkg::age_done;
                  else
                     state <= age_read;
               end
            end
            alut_ctrl_pkg::age_done:
               state <= age_idle;                 // age_purged holds the count
            default:
               state <= age_idle;
         endcase
      end
   end

   // --------------------------------------------------
   // status outputs, all from state
   // --------------------------------------------------
   assign init_done = (state != age_init);
   assign age_busy  = (state != age_idle);
   assign age_done  = (state == alut_ctrl_pkg::age_done);   // single cycle

   // --------------------------------------------------
   // memory port drive
   // --------------------------------------------------
   always_comb
   begin
      mem_addr  = idx;
      mem_write = (state == age_init) ||
                  (state == age_check && !busy && stale);   // purge write back
      if (state == age_init)
         mem_wdata = '0;                                      // clear whole entry
      else
         mem_wdata = {1'b0, mem_rdata[entry_w-2:0]};          // drop valid only
   end

endmodule

`default_nettype wire

// File: alut_ctrl_pkg.sv
// state encodings only; age_done here shares its name with the age checker output port
`default_nettype none

package alut_ctrl_pkg;

   // --------------------------------------------------
   // learn side fsm
   // --------------------------------------------------
   typedef enum logic [1:0] {
      addr_idle,      // waiting for pkt_valid
      addr_lookup,    // dst hash on the bus, read this edge
      addr_resolve    // compare result, learn write
   } addr_state_e;

   // --------------------------------------------------
   // age side fsm
   // --------------------------------------------------
   typedef enum logic [2:0] {
      age_init,       // clearing the table after reset
      age_idle,
      age_read,       // read one index, only while learn side is quiet
      age_check,      // staleness decision and write back
      age_done        // one cycle, end of sweep
   } age_state_e;

endpackage

`default_nettype wire

// File: alut_entry_pkg.sv
// entry layout is fixed at 83 bits and 256 entries; changing a width means changing the hash too
`default_nettype none

package alut_entry_pkg;

   // --------------------------------------------------
   // table geometry
   // --------------------------------------------------
   localparam int alut_depth = 256;         // entries
   localparam int alut_aw    = 8;           // index width
   localparam int mac_w      = 48;          // mac address
   localparam int port_w     = 2;           // four switch ports
   localparam int stamp_w    = 32;          // learn timestamp
   localparam int entry_w    = 1 + port_w + mac_w + stamp_w;  // 83

   // field positions, valid at the top, stamp at the bottom
   localparam int ent_valid_b = entry_w - 1;            // 82
   localparam int ent_port_lo = ent_valid_b - port_w;   // 80
   localparam int ent_mac_lo  = ent_port_lo - mac_w;    // 32
   localparam int ent_stamp_lo = 0;

   // fold the six mac bytes into one index byte
   function automatic logic [alut_aw-1:0] alut_hash(input logic [mac_w-1:0] mac);
      logic [alut_aw-1:0] h;
      h = '0;
      for (int i = 0; i < mac_w / 8; i++)
      begin
         h = h ^ mac[i*8 +: 8];
      end
      return h;
   endfunction

endpackage

`default_nettype wire

// File: alut_mem.sv
// no reset on the array, contents are undefined until the age checker init sweep has run
`timescale 1ns/1ps
`default_nettype none

module alut_mem
   import alut_entry_pkg::*;
(
   input  wire logic                pclk4,
   // port a, learn side
   input  wire logic [alut_aw-1:0]  addr_a,
   input  wire logic                write_a,
   input  wire logic [entry_w-1:0]  wdata_a,
   output logic      [entry_w-1:0]  rdata_a,
   // port b, age side
   input  wire logic [alut_aw-1:0]  addr_b,
   input  wire logic                write_b,
   input  wire logic [entry_w-1:0]  wdata_b,
   output logic      [entry_w-1:0]  rdata_b
);

   logic [entry_w-1:0] mem_array [alut_depth];   // table storage

   // --------------------------------------------------
   // one access per port per clock, read is registered
   // --------------------------------------------------
   always_ff @(posedge pclk4)
   begin
      if (!write_a)                         // read, data next cycle
         rdata_a <= mem_array[addr_a];
      else
         mem_array[addr_a] <= wdata_a;      // learn write

      if (!write_b)
         rdata_b <= mem_array[addr_b];
      else
         mem_array[addr_b] <= wdata_b;      // init clear or purge
   end

endmodule

`default_nettype wire

// File: alut_sva.sv
// bound into alut_top; learn side handshake and pulse rules, all disabled during reset
`timescale 1ns/1ps
`default_nettype none

module alut_sva
(
   input wire logic pclk4,
   input wire logic rst_n,
   input wire logic pkt_valid,
   input wire logic busy,
   input wire logic fwd_valid,
   input wire logic age_done,
   input wire logic init_done
);

   // --------------------------------------------------
   // learn side timing
   // --------------------------------------------------
   a_fwd_latency: assert property (@(posedge pclk4) disable iff (!rst_n)
      fwd_valid == $past(pkt_valid, 3))   // registered at sample edge + 2
      else $error("fwd_valid not 2 cycles after pkt_valid");

   a_busy_frame: assert property (@(posedge pclk4) disable iff (!rst_n)
      ($past(pkt_valid) || $past(pkt_valid, 2)) |-> busy)
      else $error("busy low while a frame is in flight");

   a_pkt_legal: assert property (@(posedge pclk4) disable iff (!rst_n)
      pkt_valid |-> (!busy && init_done))
      else $error("pkt_valid given while busy or before init_done");

   // single cycle pulses
   a_fwd_pulse: assert property (@(posedge pclk4) disable iff (!rst_n)
      fwd_valid |=> !fwd_valid)
      else $error("fwd_valid longer than one cycle");

   a_age_pulse: assert property (@(posedge pclk4) disable iff (!rst_n)
      age_done |=> !age_done)
      else $error("age_done longer than one cycle");

endmodule

bind alut_top alut_sva i_sva (
   .pclk4     (pclk4),
   .rst_n     (rst_n),
   .pkt_valid (pkt_valid),
   .busy      (busy),
   .fwd_valid (fwd_valid),
   .age_done  (age_done),
   .init_done (init_done)
);

`default_nettype wire

// File: alut_top.sv
// timestamp wraps at 2^32; pkt_valid needs init_done high and busy low, age_start needs age_busy low
`timescale 1ns/1ps
`default_nettype none

module alut_top
   import alut_entry_pkg::*;
(
   input  wire logic                pclk4,
   input  wire logic                rst_n,
   // frame side
   input  wire logic                pkt_valid,
   input  wire logic [mac_w-1:0]    src_mac,
   input  wire logic [mac_w-1:0]    dst_mac,
   input  wire logic [port_w-1:0]   src_port,
   // time and aging
   input  wire logic                time_tick,
   input  wire logic                age_start,
   input  wire logic [stamp_w-1:0]  age_limit,
   // results
   output logic                     busy,
   output logic                     fwd_valid,
   output logic                     fwd_hit,
   output logic      [port_w-1:0]   fwd_port,
   output logic                     init_done,
   output logic                     age_busy,
   output logic                     age_done,
   output logic      [alut_aw:0]    age_purged
);

   logic [stamp_w-1:0] now;            // current timestamp

   // learn port
   logic [alut_aw-1:0] add_addr;
   logic               add_write;
   logic [entry_w-1:0] add_wdata;
   logic [entry_w-1:0] add_rdata;
   // age port
   logic [alut_aw-1:0] age_addr;
   logic               age_write;
   logic [entry_w-1:0] age_wdata;
   logic [entry_w-1:0] age_rdata;

   // --------------------------------------------------
   // timestamp, one step per tick
   // --------------------------------------------------
   always_ff @(posedge pclk4 or negedge rst_n)
   begin
      if (!rst_n)
         now <= '0;
      else if (time_tick)
         now <= now + 1'b1;
   end

   alut_mem i_mem (
      .pclk4   (pclk4),
      .addr_a  (add_addr),  .write_a (add_write), .wdata_a (add_wdata), .rdata_a (add_rdata),
      .addr_b  (age_addr),  .write_b (age_write), .wdata_b (age_wdata), .rdata_b (age_rdata)
   );

   alut_addr_checker i_addr (
      .pclk4     (pclk4),     .rst_n     (rst_n),
      .pkt_valid (pkt_valid), .src_mac   (src_mac),  .dst_mac  (dst_mac),
      .src_port  (src_port),  .now       (now),
      .busy      (busy),      .fwd_valid (fwd_valid), .fwd_hit (fwd_hit),
      .fwd_port  (fwd_port),
      .mem_addr  (add_addr),  .mem_write (add_write), .mem_wdata (add_wdata),
      .mem_rdata (add_rdata)
   );

   alut_age_checker i_age (
      .pclk4      (pclk4),      .rst_n     (rst_n),     .busy      (busy),
      .age_start  (age_start),  .age_limit (age_limit), .now       (now),
      .init_done  (init_done),  .age_busy  (age_busy),  .age_done  (age_done),
      .age_purged (age_purged),
      .mem_addr   (age_addr),   .mem_write (age_write), .mem_wdata (age_wdata),
      .mem_rdata  (age_rdata)
   );

endmodule

`default_nettype wire

// File: flist.f
alut_entry_pkg.sv
alut_ctrl_pkg.sv
alut_mem.sv
alut_addr_checker.sv
alut_age_checker.sv
alut_top.sv
alut_sva.sv
tb_alut.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the alut testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_alut -f flist.f -o tb_alut_sim

sim_out=$(./obj_dir/tb_alut_sim 2>&1) || true
echo "$sim_out"

if grep -qx "ALL CHECKS PASSED" <<< "$sim_out"; then
   exit 0
fi
exit 1

// File: tb_alut.sv
// self-checking testbench for alut_top; stops at the first error, needs --timing on verilator
`timescale 1ns/1ps
`default_nettype none

module tb_alut
   import alut_entry_pkg::*;
();

   localparam int frame_cnt = 186;   // all frames issued below
   localparam int sweep_cnt = 2;
   localparam int cyc_limit = 2 * (16 + 256 + frame_cnt * 4 + sweep_cnt * 600) + 200;

   logic                pclk4;
   logic                rst_n;
   logic                pkt_valid;
   logic [mac_w-1:0]    src_mac;
   logic [mac_w-1:0]    dst_mac;
   logic [port_w-1:0]   src_port;
   logic                time_tick;
   logic                age_start;
   logic [stamp_w-1:0]  age_limit;
   logic                busy;
   logic                fwd_valid;
   logic                fwd_hit;
   logic [port_w-1:0]   fwd_port;
   logic                init_done;
   logic                age_busy;
   logic                age_done;
   logic [alut_aw:0]    age_purged;

   // reference table and stimulus state
   logic                ref_valid [alut_depth];
   logic [port_w-1:0]   ref_port  [alut_depth];
   logic [mac_w-1:0]    ref_mac   [alut_depth];
   logic [stamp_w-1:0]  ref_stamp [alut_depth];
   logic [stamp_w-1:0]  ref_now;
   logic                sweep_mask [alut_depth];   // indices the running sweep will purge
   logic [mac_w-1:0]    mac_pool [32];
   logic [31:0]         rng;
   int                  cyc = 0;
   logic                exp_hit_q [$];
   logic [port_w-1:0]   exp_port_q [$];
   int                  exp_cyc_q [$];
   int                  exp_purge_q [$];

   alut_top i_dut (
      .pclk4 (pclk4), .rst_n (rst_n), .pkt_valid (pkt_valid), .src_mac (src_mac),
      .dst_mac (dst_mac), .src_port (src_port), .time_tick (time_tick),
      .age_start (age_start), .age_limit (age_limit), .busy (busy),
      .fwd_valid (fwd_valid), .fwd_hit (fwd_hit), .fwd_port (fwd_port),
      .init_done (init_done), .age_busy (age_busy), .age_done (age_done),
      .age_purged (age_purged)
   );

   always #5 pclk4 = ~pclk4;

   // --------------------------------------------------
   // helpers and reference model
   // --------------------------------------------------
   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      return y ^ (y << 5);
   endfunction

   function automatic logic [alut_aw-1:0] mac_index(input logic [mac_w-1:0] mac);
      logic [7:0] h;
      h = 8'h00;
      for (int b = 0; b < 6; b++)
      begin
         h = h ^ mac[b*8 +: 8];   // byte fold
      end
      return h;
   endfunction

   // expected {hit, port} for a destination, taken before the learn
   function automatic logic [port_w:0] ref_lookup(input logic [mac_w-1:0] mac);
      logic [alut_aw-1:0] i;
      i = mac_index(mac);
      if (ref_valid[i] && ref_mac[i] == mac)
         return {1'b1, ref_port[i]};
      return '0;                  // miss floods, port 0
   endfunction

   function automatic logic is_stale(input logic [alut_aw-1:0] i, input logic [stamp_w-1:0] lim);
      logic [stamp_w-1:0] age;
      age = ref_now - ref_stamp[i];   // wraps mod 2^32
      return ref_valid[i] && (age > lim);
   endfunction

   function automatic logic masked(input logic [mac_w-1:0] s, input logic [mac_w-1:0] d);
      return sweep_mask[mac_index(s)] || sweep_mask[mac_index(d)];
   endfunction

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("CHECKS FAILED");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
      if (got !== exp)
         abort_run($sformatf("Fail %s got 0x%0h expected 0x%0h", name, got, exp));
   endtask

   // --------------------------------------------------
   // stimulus tasks, all start and end on a falling edge
   // --------------------------------------------------
   task automatic send_frame(input logic [mac_w-1:0] smac, input logic [mac_w-1:0] dmac,
                             input logic [port_w-1:0] sport);
      logic [port_w:0]    r;
      logic [alut_aw-1:0] si;
      r = ref_lookup(dmac);
      exp_hit_q.push_back(r[port_w]);
      exp_port_q.push_back(r[port_w-1:0]);
      exp_cyc_q.push_back(cyc + 3);          // sample edge + 2, seen on the next fall
      si = mac_index(smac);
      ref_valid[si] = 1'b1;                  // learn after lookup
      ref_mac[si]   = smac;
      ref_port[si]  = sport;
      ref_stamp[si] = ref_now;
      src_mac   = smac;
      dst_mac   = dmac;
      src_port  = sport;
      pkt_valid = 1'b1;
      @(negedge pclk4);
      pkt_valid = 1'b0;
      while (busy)
      begin
         @(negedge pclk4);
      end
   endtask

   task automatic tick_time(input int n);
      repeat (n)
      begin
         time_tick = 1'b1;
         ref_now   = ref_now + 1;
         @(negedge pclk4);
         time_tick = 1'b0;
      end
   endtask

   task automatic random_frames(input int count, input logic in_sweep);
      logic [mac_w-1:0] s;
      logic [mac_w-1:0] d;
      int               tries;
      for (int f = 0; f < count; f++)
      begin
         rng   = xorshift(rng);
         s     = mac_pool[rng[4:0]];
         d     = mac_pool[rng[12:8]];
         tries = 0;
         while (in_sweep && masked(s, d) && tries < 40)   // keep clear of purge targets
         begin
            rng = xorshift(rng);
            s   = mac_pool[rng[4:0]];
            d   = mac_pool[rng[12:8]];
            tries++;
         end
         if (in_sweep && masked(s, d))
            continue;
         send_frame(s, d, rng[17:16]);
         if (rng[20])
            @(negedge pclk4);                 // idle gap
         if (!in_sweep && rng[27:24] == 4'h0)
            tick_time(1);
      end
   endtask

   task automatic start_sweep(input logic [stamp_w-1:0] lim);
      int cnt;
      cnt = 0;
      for (int i = 0; i < alut_depth; i++)
      begin
         sweep_mask[i] = is_stale(alut_aw'(i), lim);
         if (sweep_mask[i])
         begin
            cnt++;
            ref_valid[i] = 1'b0;
         end
      end
      exp_purge_q.push_back(cnt);
      age_limit = lim;
      age_start = 1'b1;
      @(negedge pclk4);
      age_start = 1'b0;
   endtask

   task automatic wait_sweep();
      while (age_busy)
      begin
         @(negedge pclk4);
      end
   endtask

   // --------------------------------------------------
   // cycle counter and timeout
   // --------------------------------------------------
   always @(posedge pclk4)
   begin
      cyc <= cyc + 1;
      if (cyc >= cyc_limit)
         abort_run("timeout, the run did not finish within the cycle limit");
   end

   // --------------------------------------------------
   // compare process, outputs stable on the falling edge
   // --------------------------------------------------
   always @(negedge pclk4)
   begin
      logic              e_hit;
      logic [port_w-1:0] e_port;
      int                e_cyc;
      int                e_purge;
      if (rst_n && fwd_valid)
      begin
         if (exp_hit_q.size() == 0)
            abort_run("fwd_valid pulsed with no frame outstanding");
         e_hit  = exp_hit_q.pop_front();
         e_port = exp_port_q.pop_front();
         e_cyc  = exp_cyc_q.pop_front();
         if (cyc != e_cyc)
            abort_run("fwd_valid did not come 2 cycles after pkt_valid");
         check_eq("fwd_hit", 64'(fwd_hit), 64'(e_hit));
         check_eq("fwd_port", 64'(fwd_port), 64'(e_port));
      end
      if (rst_n && age_done)
      begin
         if (exp_purge_q.size() == 0)
            abort_run("age_done pulsed with no sweep outstanding");
         e_purge = exp_purge_q.pop_front();
         check_eq("age_purged", 64'(age_purged), 64'(e_purge));
      end
   end

   // --------------------------------------------------
   // main sequence
   // --------------------------------------------------
   initial
   begin
      int n;
      pclk4     = 1'b0;
      rst_n     = 1'b0;
      pkt_valid = 1'b0;
      src_mac   = '0;
      dst_mac   = '0;
      src_port  = '0;
      time_tick = 1'b0;
      age_start = 1'b0;
      age_limit = '0;
      rng       = 32'h7b0;
      ref_now   = '0;
      for (int i = 0; i < alut_depth; i++)
      begin
         ref_valid[i]  = 1'b0;
         sweep_mask[i] = 1'b0;
      end
      for (int i = 0; i < 16; i++)
      begin
         rng = xorshift(rng);
         mac_pool[i][47:32] = rng[15:0];
         rng = xorshift(rng);
         mac_pool[i][31:0] = rng;
         mac_pool[i + 16] = mac_pool[i] ^ 48'h0000_0000_3c3c;   // same hash, other mac
      end
      repeat (16) @(negedge pclk4);
      check_eq("busy", 64'(busy), 64'(0));
      check_eq("fwd_valid", 64'(fwd_valid), 64'(0));
      check_eq("age_done", 64'(age_done), 64'(0));
      check_eq("init_done", 64'(init_done), 64'(0));
      check_eq("age_busy", 64'(age_busy), 64'(1));
      rst_n = 1'b1;
      n = 0;
      while (!init_done && n < 300)
      begin
         @(negedge pclk4);
         n++;
      end
      if (!init_done)
         abort_run("init_done never rose after the table clear");
      check_eq("init_done delay", 64'(n), 64'(256));
      random_frames(24, 1'b0);                           // cold table, mostly misses
      send_frame(mac_pool[1], mac_pool[20], 2'd1);
      send_frame(mac_pool[17], mac_pool[3], 2'd2);        // overwrites pool 1
      send_frame(mac_pool[5], mac_pool[1], 2'd3);
      send_frame(mac_pool[6], mac_pool[17], 2'd0);
      tick_time(3);
      random_frames(40, 1'b0);
      tick_time(8);
      start_sweep(32'd6);
      wait_sweep();
      for (int i = 0; i < 32; i++)
      begin
         send_frame(mac_pool[i], mac_pool[i], 2'(i));   // purged macs must miss
      end
      tick_time(5);
      random_frames(16, 1'b0);                           // fresh entries survive the sweep
      start_sweep(32'd4);
      random_frames(40, 1'b1);                           // frames race the sweep
      wait_sweep();
      random_frames(30, 1'b0);
      repeat (4) @(negedge pclk4);
      if (exp_hit_q.size() != 0 || exp_purge_q.size() != 0)
         abort_run("results still outstanding at the end of the run");
      else
      begin
         $display("ALL CHECKS PASSED");
         $finish;
      end
   end

endmodule

`default_nettype wire
